/* compile.f */
logic/robotLinkPkg.sv
logic/cmdSpeedTable.sv
logic/speedFieldFormatter.sv
logic/jsonFrameBuilder.sv
logic/frameSequencer.sv
logic/uartTx.sv
logic/robotLinkTop.sv
dv/robotLinkTb.sv

/* dv/robotLinkTb.sv */
`timescale 1ns/1ps
`default_nettype none

module robotLinkTb;

    localparam int bitClks    = 4;                              // Fast baud for simulation
    localparam int drvDelay   = 2;                              // ns after rising edge
    localparam int numFrames  = 58;                             // 10 + 6 + 2 + 40
    localparam int frameBound = robotLinkPkg::maxFrameLen * 10 * bitClks
                              + robotLinkPkg::gapCycles;
    localparam int watchdogCycles = numFrames * frameBound * 2 + 8;

    typedef logic [robotLinkPkg::frameLenW-1:0] lenT;

    logic clk;
    logic rst;
    robotLinkPkg::cmdT cmd;
    logic txd;
    logic done;
    logic [17:0] ledr;

    robotLinkPkg::byteT rxQ[$];                                 // Bytes of frame in progress
    robotLinkPkg::cmdT expCmdQ[$];                              // One command per frame
    int errCount;
    int checkCount;
    int frameCount;
    logic prevDone;

    robotLinkTop #(
        .clksPerBit (bitClks)
    ) dut0 (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd),
        .txd  (txd),
        .done (done),
        .ledr (ledr)
    );

    always #20 clk = ~clk;                                      // 40 ns period

    task automatic checkByte(input string name, input robotLinkPkg::byteT got,
                             input robotLinkPkg::byteT expVal);
        checkCount++;
        if (got !== expVal) begin
            errCount++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expVal);
        end
    endtask

    task automatic checkCmd(input string name, input robotLinkPkg::cmdT got,
                            input robotLinkPkg::cmdT expVal);
        checkCount++;
        if (got !== expVal) begin
            errCount++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expVal);
        end
    endtask

    task automatic checkLen(input string name, input lenT got, input lenT expVal);
        checkCount++;
        if (got !== expVal) begin
            errCount++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expVal);
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic expVal);
        checkCount++;
        if (got !== expVal) begin
            errCount++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expVal);
        end
    endtask

    task automatic checkLeds(input string name, input logic [17:0] got,
                             input logic [17:0] expVal);
        checkCount++;
        if (got !== expVal) begin
            errCount++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expVal);
        end
    endtask

    // Left wheel text per command
    function automatic string leftSpeed(input robotLinkPkg::cmdT c);
        case (c)
            robotLinkPkg::cmdLeft:         return "-0.00";
            robotLinkPkg::cmdRight:        return "0.12";
            robotLinkPkg::cmdFwdSlow:      return "0.05";
            robotLinkPkg::cmdFwdMedium:    return "0.25";
            robotLinkPkg::cmdFwdFast:      return "0.5";
            robotLinkPkg::cmdReverse:      return "-0.10";
            robotLinkPkg::cmdLeftReverse:  return "-0.00";
            robotLinkPkg::cmdRightReverse: return "-0.10";
            robotLinkPkg::cmdHardLeft:     return "-0.12";
            default:                       return "0";          // Stop and unused codes
        endcase
    endfunction

    // Right wheel text per command
    function automatic string rightSpeed(input robotLinkPkg::cmdT c);
        case (c)
            robotLinkPkg::cmdLeft:         return "0.12";
            robotLinkPkg::cmdRight:        return "-0.00";
            robotLinkPkg::cmdFwdSlow:      return "0.05";
            robotLinkPkg::cmdFwdMedium:    return "0.25";
            robotLinkPkg::cmdFwdFast:      return "0.5";
            robotLinkPkg::cmdReverse:      return "-0.10";
            robotLinkPkg::cmdLeftReverse:  return "-0.10";
            robotLinkPkg::cmdRightReverse: return "-0.00";
            robotLinkPkg::cmdHardLeft:     return "0.12";
            default:                       return "0";
        endcase
    endfunction

    // Whole JSON line, its length is the string length
    function automatic string expectFrame(input robotLinkPkg::cmdT c);
        return {"{\"T\":1,\"L\":", leftSpeed(c), ",\"R\":", rightSpeed(c), "}\n"};
    endfunction

    // UART receiver, sampling near mid-bit on falling clock edges
    task automatic receiveByte();
        robotLinkPkg::byteT data;
        data = '0;
        repeat (bitClks / 2) @(negedge clk);
        if (txd !== 1'b0) begin
            errCount++;
            $display("Start bit on txd ended early, glitch on the line");
        end
        checkLevel("ledr[17]", ledr[17], 1'b1);                 // Busy while byte on the line
        for (int b = 0; b < 8; b++) begin
            repeat (bitClks) @(negedge clk);
            data[b] = txd;                                      // LSB first
        end
        repeat (bitClks) @(negedge clk);
        if (txd !== 1'b1) begin
            errCount++;
            $display("Missing stop bit after byte 0x%h", data);
        end
        rxQ.push_back(data);
    endtask

    always @(negedge clk) begin
        if (!rst && txd === 1'b0) begin
            receiveByte();
        end
    end

    // Compares one finished frame with the reference
    task automatic checkFrame();
        string expText;
        robotLinkPkg::cmdT c;
        int errBefore;
        int n;
        errBefore = errCount;
        if (expCmdQ.size() == 0) begin
            errCount++;
            $display("Frame ended while no command was queued for it");
        end else begin
            c = expCmdQ.pop_front();
            expText = expectFrame(c);
            checkLen("frame length", lenT'(rxQ.size()), lenT'(expText.len()));
            n = (rxQ.size() < expText.len()) ? rxQ.size() : expText.len();
            for (int i = 0; i < n; i++) begin
                checkByte($sformatf("frame byte %0d", i), rxQ[i],
                          robotLinkPkg::byteT'(expText[i]));
            end
            checkCmd("ledr[11:8]", ledr[11:8], c);              // Latched command on LEDs
            checkByte("ledr[7:0]", ledr[7:0],
                      robotLinkPkg::byteT'(expText[expText.len() - 1]));  // Last byte sent
            checkLevel("ledr[17]", ledr[17], 1'b0);             // Line idle at done
            if (errCount == errBefore) begin
                $display("frame %0d cmd 0x%h: ok", frameCount + 1, c);
            end else begin
                $display("frame %0d cmd 0x%h: mismatch", frameCount + 1, c);
            end
        end
        rxQ.delete();
        frameCount++;
    endtask

    always @(negedge clk) begin
        if (!rst && done) begin
            if (prevDone) begin
                errCount++;
                $display("done stayed high for more than one cycle");
            end else begin
                checkFrame();
            end
        end
        prevDone = done;
    end

    task automatic driveCmd(input robotLinkPkg::cmdT c);
        @(posedge clk);
        #drvDelay;
        cmd = c;
    endtask

    // Sets the command in the gap, then waits for its frame to be checked
    task automatic runFrame(input robotLinkPkg::cmdT c);
        int target;
        target = frameCount + 1;
        driveCmd(c);
        expCmdQ.push_back(c);
        while (frameCount != target) @(posedge clk);
    endtask

    task automatic midFrameChange(input robotLinkPkg::cmdT first,
                                  input robotLinkPkg::cmdT second);
        int target;
        target = frameCount + 2;
        driveCmd(first);
        expCmdQ.push_back(first);
        while (rxQ.size() < 6) @(posedge clk);                  // Frame already on the line
        driveCmd(second);
        expCmdQ.push_back(second);                              // Takes effect next frame
        while (frameCount != target) @(posedge clk);
    endtask

    initial begin : mainFlow
        int errBefore;
        void'($urandom(3948));
        clk        = 1'b0;
        rst        = 1'b1;
        cmd        = robotLinkPkg::cmdStop;
        prevDone   = 1'b0;
        errCount   = 0;
        checkCount = 0;
        frameCount = 0;
        repeat (8) @(posedge clk);
        #drvDelay;
        rst = 1'b0;
        @(negedge clk);
        errBefore = errCount;
        checkLevel("txd", txd, 1'b1);                           // Line idles high
        checkLevel("done", done, 1'b0);
        checkLeds("ledr", ledr, 18'd0);
        if (errCount == errBefore) begin
            $display("reset state: ok");
        end else begin
            $display("reset state: mismatch");
        end
        for (int i = 0; i < 10; i++) begin                      // Defined commands
            runFrame(robotLinkPkg::cmdT'(i));
        end
        for (int i = 10; i < 16; i++) begin                     // Unused codes act as stop
            runFrame(robotLinkPkg::cmdT'(i));
        end
        midFrameChange(robotLinkPkg::cmdFwdFast, robotLinkPkg::cmdReverse);
        repeat (40) begin
            runFrame(robotLinkPkg::cmdT'($urandom % 16));
        end
        $display("%0d frames, %0d checks, %0d errors", frameCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout, frames stopped arriving before all tests ended");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/cmdSpeedTable.sv */
`timescale 1ns/1ps
`default_nettype none

module cmdSpeedTable (
    input  wire robotLinkPkg::cmdT cmd,
    output robotLinkPkg::speedPairT speeds
);

    // Speed values used by the command set
    localparam robotLinkPkg::speedT spZero =
        '{neg: 1'b0, fracDigits: 2'd0, tenths: 4'd0, hundredths: 4'd0};    // "0"
    localparam robotLinkPkg::speedT spNegZero =
        '{neg: 1'b1, fracDigits: 2'd2, tenths: 4'd0, hundredths: 4'd0};    // "-0.00"
    localparam robotLinkPkg::speedT spPos12 =
        '{neg: 1'b0, fracDigits: 2'd2, tenths: 4'd1, hundredths: 4'd2};    // "0.12"
    localparam robotLinkPkg::speedT spNeg12 =
        '{neg: 1'b1, fracDigits: 2'd2, tenths: 4'd1, hundredths: 4'd2};    // "-0.12"
    localparam robotLinkPkg::speedT spPos05 =
        '{neg: 1'b0, fracDigits: 2'd2, tenths: 4'd0, hundredths: 4'd5};    // "0.05"
    localparam robotLinkPkg::speedT spPos25 =
        '{neg: 1'b0, fracDigits: 2'd2, tenths: 4'd2, hundredths: 4'd5};    // "0.25"
    localparam robotLinkPkg::speedT spPos5 =
        '{neg: 1'b0, fracDigits: 2'd1, tenths: 4'd5, hundredths: 4'd0};    // "0.5"
    localparam robotLinkPkg::speedT spNeg10 =
        '{neg: 1'b1, fracDigits: 2'd2, tenths: 4'd1, hundredths: 4'd0};    // "-0.10"

    always_comb begin
        case (cmd)
            robotLinkPkg::cmdLeft: begin                        // Pivot left
                speeds.left  = spNegZero;
                speeds.right = spPos12;
            end
            robotLinkPkg::cmdRight: begin                       // Pivot right
                speeds.left  = spPos12;
                speeds.right = spNegZero;
            end
            robotLinkPkg::cmdFwdSlow: begin
                speeds.left  = spPos05;
                speeds.right = spPos05;
            end
            robotLinkPkg::cmdFwdMedium: begin
                speeds.left  = spPos25;
                speeds.right = spPos25;
            end
            robotLinkPkg::cmdFwdFast: begin                     // Single fraction digit
                speeds.left  = spPos5;
                speeds.right = spPos5;
            end
            robotLinkPkg::cmdReverse: begin
                speeds.left  = spNeg10;
                speeds.right = spNeg10;
            end
            robotLinkPkg::cmdLeftReverse: begin
                speeds.left  = spNegZero;
                speeds.right = spNeg10;
            end
            robotLinkPkg::cmdRightReverse: begin
                speeds.left  = spNeg10;
                speeds.right = spNegZero;
            end
            robotLinkPkg::cmdHardLeft: begin                    // Wheels counter-rotate
                speeds.left  = spNeg12;
                speeds.right = spPos12;
            end
            default: begin                                      // Stop and unused codes
                speeds.left  = spZero;
                speeds.right = spZero;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/frameSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frameSequencer (
    input  wire logic clk,
    input  wire logic rst,
    input  wire robotLinkPkg::cmdT cmd,
    input  wire robotLinkPkg::byteT [robotLinkPkg::maxFrameLen-1:0] frameBytes,
    input  wire logic [robotLinkPkg::frameLenW-1:0] frameLen,
    input  wire logic txBusy,
    output robotLinkPkg::cmdT curCmd,
    output robotLinkPkg::byteT txByte,
    output logic txStart,
    output logic done,
    output robotLinkPkg::byteT sentByte
);

    localparam int gapW = $clog2(robotLinkPkg::gapCycles);

    typedef enum logic [2:0] {
        sGap,                                                   // Idle between frames
        sLatch,                                                 // Capture cmd
        sSend,                                                  // Hand byte to UART
        sWaitBusy,                                              // Byte on the line
        sFinish                                                 // One-cycle done
    } stateT;

    stateT state;
    logic [gapW-1:0] gapCnt;
    logic [robotLinkPkg::frameLenW-1:0] idx;                    // Current frame byte
    logic lastByte;

    assign lastByte = (idx == frameLen - 5'd1);
    assign txStart  = (state == sSend) && !txBusy;              // Never overlaps a busy line
    assign txByte   = frameBytes[idx];
    assign done     = (state == sFinish);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= sGap;
            gapCnt   <= '0;
            idx      <= '0;
            curCmd   <= robotLinkPkg::cmdStop;
            sentByte <= '0;                                     // LEDs dark after reset
        end else begin
            case (state)
                sGap: begin
                    if (gapCnt == gapW'(robotLinkPkg::gapCycles - 1)) begin
                        gapCnt <= '0;
                        state  <= sLatch;
                    end else begin
                        gapCnt <= gapCnt + 1'b1;
                    end
                end
                sLatch: begin
                    curCmd <= cmd;                              // Held for the whole frame
                    idx    <= '0;
                    state  <= sSend;
                end
                sSend: begin
                    if (!txBusy) begin
                        sentByte <= frameBytes[idx];
                        state    <= sWaitBusy;                  // Busy rises on this edge
                    end
                end
                sWaitBusy: begin
                    if (!txBusy) begin                          // Stop bit finished
                        if (lastByte) begin
                            state <= sFinish;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= sSend;
                        end
                    end
                end
                sFinish: begin
                    state <= sGap;
                end
                default: begin
                    state <= sGap;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/jsonFrameBuilder.sv */
`timescale 1ns/1ps
`default_nettype none

module jsonFrameBuilder (
    input  wire robotLinkPkg::fieldT leftField,
    input  wire robotLinkPkg::fieldT rightField,
    output robotLinkPkg::byteT [robotLinkPkg::maxFrameLen-1:0] frameBytes,  // Entry 0 sent first
    output logic [robotLinkPkg::frameLenW-1:0] frameLen
);

    localparam int prefixLen = 11;
    localparam int midLen    = 5;
    localparam logic [8*prefixLen-1:0] prefixText = "{\"T\":1,\"L\":";
    localparam logic [8*midLen-1:0]    midText    = ",\"R\":";
    localparam robotLinkPkg::byteT charClose   = 8'h7D;        // '}'
    localparam robotLinkPkg::byteT charNewline = 8'h0A;

    logic [robotLinkPkg::frameLenW-1:0] midOfs;                 // Start of ,"R":
    logic [robotLinkPkg::frameLenW-1:0] rightOfs;               // Start of right number
    logic [robotLinkPkg::frameLenW-1:0] tailOfs;                // Position of closing brace

    assign midOfs   = robotLinkPkg::frameLenW'(prefixLen) + {2'd0, leftField.len};
    assign rightOfs = midOfs + robotLinkPkg::frameLenW'(midLen);
    assign tailOfs  = rightOfs + {2'd0, rightField.len};
    assign frameLen = robotLinkPkg::frameLenW'(robotLinkPkg::fixedFrameLen)
                    + {2'd0, leftField.len} + {2'd0, rightField.len};

    always_comb begin
        frameBytes = '0;                                        // Unused tail stays zero
        for (int i = 0; i < prefixLen; i++) begin
            frameBytes[i] = prefixText[8*(prefixLen-1-i) +: 8]; // Top byte of literal first
        end
        for (int i = 0; i < 5; i++) begin
            if (i < int'(leftField.len)) begin
                frameBytes[prefixLen + i] = leftField.chars[4 - i];
            end
        end
        for (int i = 0; i < midLen; i++) begin
            frameBytes[midOfs + robotLinkPkg::frameLenW'(i)] = midText[8*(midLen-1-i) +: 8];
        end
        for (int i = 0; i < 5; i++) begin
            if (i < int'(rightField.len)) begin
                frameBytes[rightOfs + robotLinkPkg::frameLenW'(i)] = rightField.chars[4 - i];
            end
        end
        frameBytes[tailOfs]        = charClose;
        frameBytes[tailOfs + 5'd1] = charNewline;               // Frame terminator
    end

endmodule

`default_nettype wire

/* logic/robotLinkPkg.sv */
`default_nettype none

package robotLinkPkg;

    typedef logic [3:0] cmdT;                       // Motion command code
    typedef logic [7:0] byteT;                      // One ASCII character

    localparam cmdT cmdStop         = 4'd0;
    localparam cmdT cmdLeft         = 4'd1;
    localparam cmdT cmdRight        = 4'd2;
    localparam cmdT cmdFwdSlow      = 4'd3;
    localparam cmdT cmdFwdMedium    = 4'd4;
    localparam cmdT cmdFwdFast      = 4'd5;
    localparam cmdT cmdReverse      = 4'd6;
    localparam cmdT cmdLeftReverse  = 4'd7;
    localparam cmdT cmdRightReverse = 4'd8;
    localparam cmdT cmdHardLeft     = 4'd9;         // Codes 10..15 fall back to stop

    // One wheel speed as sign plus up to two fraction digits
    typedef struct packed {
        logic       neg;                            // Leading minus sign
        logic [1:0] fracDigits;                     // 0 prints just "0"
        logic [3:0] tenths;                         // BCD digit after the point
        logic [3:0] hundredths;                     // BCD second digit
    } speedT;

    typedef struct packed {
        speedT left;
        speedT right;
    } speedPairT;

    // Rendered number text, first character in the top byte
    typedef struct packed {
        byteT [4:0] chars;
        logic [2:0] len;                            // 1 to 5 valid characters
    } fieldT;

    localparam int maxFrameLen   = 28;              // Both fields at five chars
    localparam int frameLenW     = 5;               // Holds 0..31
    localparam int fixedFrameLen = 18;              // Prefix, separator, brace, newline
    localparam int gapCycles     = 16;              // Idle clocks between frames

endpackage

`default_nettype wire

/* logic/robotLinkTop.sv */
`timescale 1ns/1ps
`default_nettype none

module robotLinkTop #(
    parameter int clksPerBit = 434
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire robotLinkPkg::cmdT cmd,
    output logic txd,
    output logic done,
    output logic [17:0] ledr
);

    robotLinkPkg::cmdT curCmd;                                  // Command of frame in flight
    robotLinkPkg::speedPairT speeds;
    robotLinkPkg::fieldT leftField;
    robotLinkPkg::fieldT rightField;
    robotLinkPkg::byteT [robotLinkPkg::maxFrameLen-1:0] frameBytes;
    logic [robotLinkPkg::frameLenW-1:0] frameLen;
    robotLinkPkg::byteT txByte;
    robotLinkPkg::byteT sentByte;
    logic txStart;
    logic txBusy;

    cmdSpeedTable speedTable0 (
        .cmd    (curCmd),
        .speeds (speeds)
    );

    speedFieldFormatter fmtLeft (
        .speed (speeds.left),
        .field (leftField)
    );

    speedFieldFormatter fmtRight (
        .speed (speeds.right),
        .field (rightField)
    );

    jsonFrameBuilder builder0 (
        .leftField  (leftField),
        .rightField (rightField),
        .frameBytes (frameBytes),
        .frameLen   (frameLen)
    );

    frameSequencer sequencer0 (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .frameBytes (frameBytes),
        .frameLen   (frameLen),
        .txBusy     (txBusy),
        .curCmd     (curCmd),
        .txByte     (txByte),
        .txStart    (txStart),
        .done       (done),
        .sentByte   (sentByte)
    );

    uartTx #(
        .clksPerBit (clksPerBit)
    ) uartTx0 (
        .clk     (clk),
        .rst     (rst),
        .txStart (txStart),
        .txByte  (txByte),
        .txd     (txd),
        .txBusy  (txBusy)
    );

    // Busy on 17, latched command on 11:8, last byte on 7:0
    assign ledr = {txBusy, 5'd0, curCmd, sentByte};

endmodule

`default_nettype wire

/* logic/speedFieldFormatter.sv */
`timescale 1ns/1ps
`default_nettype none

module speedFieldFormatter (
    input  wire robotLinkPkg::speedT speed,
    output robotLinkPkg::fieldT field
);

    localparam robotLinkPkg::byteT charMinus = 8'h2D;          // '-'
    localparam robotLinkPkg::byteT charZero  = 8'h30;          // '0'
    localparam robotLinkPkg::byteT charPoint = 8'h2E;          // '.'

    // BCD digit to ASCII
    function automatic robotLinkPkg::byteT digitChar(input logic [3:0] d);
        return charZero + {4'd0, d};
    endfunction

    // Characters are appended left to right, len is the next free slot
    always_comb begin
        field = '0;
        if (speed.neg) begin
            field.chars[4] = charMinus;                         // Sign goes first
            field.len      = 3'd1;
        end
        field.chars[3'd4 - field.len] = charZero;               // Integer part is always 0
        field.len = field.len + 3'd1;
        if (speed.fracDigits != 2'd0) begin
            field.chars[3'd4 - field.len] = charPoint;
            field.len = field.len + 3'd1;
            field.chars[3'd4 - field.len] = digitChar(speed.tenths);
            field.len = field.len + 3'd1;
            if (speed.fracDigits >= 2'd2) begin                 // Second digit only when asked
                field.chars[3'd4 - field.len] = digitChar(speed.hundredths);
                field.len = field.len + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/uartTx.sv */
`timescale 1ns/1ps
`default_nettype none

module uartTx #(
    parameter int clksPerBit = 434                              // 115200 baud at 50 MHz
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic txStart,
    input  wire robotLinkPkg::byteT txByte,
    output logic txd,
    output logic txBusy
);

    localparam int baudW = $clog2(clksPerBit);

    logic [9:0] shiftReg;                                       // Stop, data, start
    logic [3:0] bitCnt;                                         // Bit now on the line
    logic [baudW-1:0] baudCnt;                                  // Cycles into current bit
    logic bitEnd;

    assign bitEnd = (baudCnt == baudW'(clksPerBit - 1));
    assign txd    = shiftReg[0];                                // Idles high via ones fill

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shiftReg <= '1;
            bitCnt   <= '0;
            baudCnt  <= '0;
            txBusy   <= 1'b0;
        end else if (!txBusy) begin
            if (txStart) begin
                shiftReg <= {1'b1, txByte, 1'b0};               // LSB after start bit
                bitCnt   <= '0;
                baudCnt  <= '0;
                txBusy   <= 1'b1;
            end
        end else if (bitEnd) begin
            baudCnt  <= '0;
            shiftReg <= {1'b1, shiftReg[9:1]};                  // Next bit, shift in idle
            if (bitCnt == 4'd9) begin
                txBusy <= 1'b0;                                 // Stop bit done
            end else begin
                bitCnt <= bitCnt + 4'd1;
            end
        end else begin
            baudCnt <= baudCnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the robot link testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module robotLinkTb \
    -f compile.f \
    -Mdir obj_dir \
    -o robotLinkSim

out=$(./obj_dir/robotLinkSim)
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS"
